// ==== source/fetch_macros.svh ====
// ---------------------------------------------------------
// Global widths and boot address for the fetch branch unit
// Include wherever a width or the reset PC is needed
// ---------------------------------------------------------

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Address width in bits
`define XLEN 32

// Low address bits dropped for word aligned fetch
`define OFFSET 2

// BTB index width, 16 rows
`define BTB_BITS 4

// BHT index width, 32 counters
`define BHT_BITS 5

// First fetch address after reset
`define BOOT_PC 32'h0000_0100

`endif

// ==== source/fetch_pkg.sv ====
// ---------------------------------------------------------
// Shared address, index and counter types of the fetch unit
// ---------------------------------------------------------

`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // Full byte address
  typedef logic [`XLEN-1:0] xlen_t;

  // Address without its offset bits, as the BTB stores targets
  typedef logic [`XLEN-`OFFSET-1:0] word_addr_t;

  // BTB row select and tag
  typedef logic [`BTB_BITS-1:0] btb_idx_t;
  typedef logic [`XLEN-`BTB_BITS-`OFFSET-1:0] btb_tag_t;

  // BHT row select
  typedef logic [`BHT_BITS-1:0] bht_idx_t;

  // Two-bit saturating counter, MSB set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } bht_cnt_t;

endpackage

`default_nettype wire

// ==== source/resolution_if.sv ====
// ---------------------------------------------------------
// Registered branch resolution, from input stage to tables
// One driver on src, BTB, BHT and PC generator listen on dst
// ---------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

interface resolution_if;

  import fetch_pkg::*;

  // One-cycle pulse, no back-pressure
  logic  valid;
  // Branch instruction address
  xlen_t pc;
  // Resolved branch target
  xlen_t target;
  // Resolved direction
  logic  taken;
  // Valid and not taken, BTB row to drop
  logic  del_entry;
  // Fetch went the wrong way, already qualified with valid
  logic  mispredict;

  // Input stage side
  modport src (
    output valid, pc, target, taken, del_entry, mispredict
  );

  // Table and PC generator side
  modport dst (
    input valid, pc, target, taken, del_entry, mispredict
  );

endinterface

`default_nettype wire

// ==== source/resolution_in.sv ====
// ---------------------------------------------------------
// Input stage, registers execute stage branch resolutions
// and derives the BTB delete and fetch redirect flags
// ---------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module resolution_in (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             res_valid_i,
  input  wire fetch_pkg::xlen_t res_pc_i,
  input  wire fetch_pkg::xlen_t res_target_i,
  input  wire logic             res_taken_i,
  input  wire logic             res_mispredict_i,
  resolution_if.src             res_o
);

  import fetch_pkg::*;

  // Control flags
  logic  valid_q;
  logic  mispredict_q;

  // Payload, only looked at while valid_q is set
  xlen_t pc_q;
  xlen_t target_q;
  logic  taken_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      mispredict_q <= 1'b0;
    end else begin
      valid_q      <= res_valid_i;
      mispredict_q <= res_mispredict_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_q     <= res_pc_i;
    target_q <= res_target_i;
    taken_q  <= res_taken_i;
  end

  // ---------------------------------------------------------
  // Drive the interface
  // ---------------------------------------------------------
  assign res_o.valid      = valid_q;
  assign res_o.pc         = pc_q;
  assign res_o.target     = target_q;
  assign res_o.taken      = taken_q;
  // Not taken branch removes its BTB row
  assign res_o.del_entry  = valid_q & ~taken_q;
  // A stray mispredict flag without valid is ignored
  assign res_o.mispredict = valid_q & mispredict_q;

endmodule

`default_nettype wire

// ==== source/btb.sv ====
// ---------------------------------------------------------
// Direct-mapped branch target buffer, read by the fetch PC
// and trained by registered branch resolutions
// ---------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module btb (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  flush_i,
  resolution_if.dst                  res_i,
  input  wire fetch_pkg::xlen_t      curr_pc_i,
  output logic                       hit_o,
  output fetch_pkg::word_addr_t      target_o
);

  import fetch_pkg::*;

  localparam int unsigned BtbRows = 1 << `BTB_BITS;

  // One row, the target is kept without its offset bits
  typedef struct packed {
    logic       valid;
    btb_tag_t   tag;
    word_addr_t target;
  } btb_entry_t;

  btb_entry_t rows_q [BtbRows];

  // Write side fields, taken from the resolved branch PC
  btb_idx_t   wr_idx;
  btb_tag_t   wr_tag;
  word_addr_t wr_target;

  // Read side fields, taken from the current fetch PC
  btb_idx_t   rd_idx;
  btb_tag_t   rd_tag;

  assign wr_idx    = res_i.pc[`BTB_BITS+`OFFSET-1:`OFFSET];
  assign wr_tag    = res_i.pc[`XLEN-1:`BTB_BITS+`OFFSET];
  assign wr_target = res_i.target[`XLEN-1:`OFFSET];

  // ---------------------------------------------------------
  // Update
  // ---------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BtbRows; i++) begin
        rows_q[i] <= '0;
      end
    end else if (flush_i) begin
      // Flush wins over a resolution in the same cycle
      for (int i = 0; i < BtbRows; i++) begin
        rows_q[i] <= '0;
      end
    end else if (res_i.valid) begin
      if (res_i.del_entry) begin
        // Dropped regardless of tag, so an alias at this row also goes
        rows_q[wr_idx] <= '0;
      end else begin
        rows_q[wr_idx].valid  <= 1'b1;
        rows_q[wr_idx].tag    <= wr_tag;
        rows_q[wr_idx].target <= wr_target;
      end
    end
  end

  // ---------------------------------------------------------
  // Lookup
  // ---------------------------------------------------------
  assign rd_idx   = curr_pc_i[`BTB_BITS+`OFFSET-1:`OFFSET];
  assign rd_tag   = curr_pc_i[`XLEN-1:`BTB_BITS+`OFFSET];

  // Hit needs a live row whose tag matches the full upper PC
  assign hit_o    = rows_q[rd_idx].valid && (rows_q[rd_idx].tag == rd_tag);
  assign target_o = rows_q[rd_idx].target;

endmodule

`default_nettype wire

// ==== source/bht.sv ====
// ---------------------------------------------------------
// Branch history table of two-bit saturating counters
// Indexed by PC, gives a taken or not taken prediction
// ---------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module bht (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             flush_i,
  resolution_if.dst             res_i,
  input  wire fetch_pkg::xlen_t curr_pc_i,
  output logic                  pred_taken_o
);

  import fetch_pkg::*;

  localparam int unsigned BhtRows = 1 << `BHT_BITS;

  bht_cnt_t cnt_q [BhtRows];

  bht_idx_t wr_idx;
  bht_idx_t rd_idx;
  bht_cnt_t rd_cnt;

  // One step toward the resolved direction, held at both ends
  function automatic bht_cnt_t cnt_step(input bht_cnt_t cnt, input logic taken);
    bht_cnt_t nxt;
    nxt = cnt;
    case (cnt)
      STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
      WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
      STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
      default:   nxt = WEAK_NT;
    endcase
    return nxt;
  endfunction

  assign wr_idx = res_i.pc[`BHT_BITS+`OFFSET-1:`OFFSET];
  assign rd_idx = curr_pc_i[`BHT_BITS+`OFFSET-1:`OFFSET];

  // ---------------------------------------------------------
  // Training, flush over resolution
  // ---------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BhtRows; i++) begin
        cnt_q[i] <= WEAK_NT;
      end
    end else if (flush_i) begin
      for (int i = 0; i < BhtRows; i++) begin
        cnt_q[i] <= WEAK_NT;
      end
    end else if (res_i.valid) begin
      cnt_q[wr_idx] <= cnt_step(cnt_q[wr_idx], res_i.taken);
    end
  end

  // Predict taken in the two upper states
  assign rd_cnt       = cnt_q[rd_idx];
  assign pred_taken_o = (rd_cnt == WEAK_T) || (rd_cnt == STRONG_T);

endmodule

`default_nettype wire

// ==== source/pc_gen.sv ====
// ---------------------------------------------------------
// Fetch PC generator, offers one address per valid/ready
// transfer and follows prediction or redirect
// ---------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module pc_gen (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  resolution_if.dst                  res_i,
  input  wire logic                  btb_hit_i,
  input  wire fetch_pkg::word_addr_t btb_target_i,
  input  wire logic                  pred_taken_i,
  input  wire logic                  fetch_ready_i,
  output logic                       fetch_valid_o,
  output fetch_pkg::xlen_t           fetch_pc_o
);

  import fetch_pkg::*;

  // Sequential step, one word
  localparam xlen_t PcStep = xlen_t'(1 << `OFFSET);

  xlen_t pc_q;
  logic  valid_q;

  // Candidate next addresses
  xlen_t pred_pc;
  xlen_t redirect_pc;
  logic  accept;

  // Predicted path, target only when both tables agree
  assign pred_pc = (btb_hit_i && pred_taken_i) ? {btb_target_i, {`OFFSET{1'b0}}}
                                               : pc_q + PcStep;

  // Correct path of a mispredicted branch
  assign redirect_pc = res_i.taken ? res_i.target : res_i.pc + PcStep;

  assign accept = valid_q && fetch_ready_i;

  // ---------------------------------------------------------
  // PC and valid registers
  // ---------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q    <= `BOOT_PC;
      valid_q <= 1'b0;
    end else begin
      // Valid comes up one edge after reset, then stays
      valid_q <= 1'b1;
      if (res_i.mispredict) begin
        // Redirect beats back-pressure and prediction
        pc_q <= redirect_pc;
      end else if (accept) begin
        pc_q <= pred_pc;
      end
      // Otherwise hold, fetch_pc_o stays stable under stall
    end
  end

  assign fetch_valid_o = valid_q;
  assign fetch_pc_o    = pc_q;

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
// ---------------------------------------------------------
// Branch prediction and next-PC top, connects input stage,
// BTB, BHT and PC generator behind plain ports
// ---------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             flush_i,
  // Resolution from execute
  input  wire logic             res_valid_i,
  input  wire fetch_pkg::xlen_t res_pc_i,
  input  wire fetch_pkg::xlen_t res_target_i,
  input  wire logic             res_taken_i,
  input  wire logic             res_mispredict_i,
  // Fetch address handshake
  output logic                  fetch_valid_o,
  output fetch_pkg::xlen_t      fetch_pc_o,
  input  wire logic             fetch_ready_i
);

  import fetch_pkg::*;

  // Prediction path
  xlen_t      curr_pc;
  logic       btb_hit;
  word_addr_t btb_target;
  logic       pred_taken;

  resolution_if u_res_if ();

  // ---------------------------------------------------------
  // Resolution input stage
  // ---------------------------------------------------------
  resolution_in u_resolution_in (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .res_taken_i      (res_taken_i),
    .res_mispredict_i (res_mispredict_i),
    .res_o            (u_res_if.src)
  );

  // ---------------------------------------------------------
  // Prediction tables
  // ---------------------------------------------------------
  btb u_btb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .res_i     (u_res_if.dst),
    .curr_pc_i (curr_pc),
    .hit_o     (btb_hit),
    .target_o  (btb_target)
  );

  bht u_bht (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .res_i        (u_res_if.dst),
    .curr_pc_i    (curr_pc),
    .pred_taken_o (pred_taken)
  );

  // PC generator, its PC also drives both table lookups
  pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_i         (u_res_if.dst),
    .btb_hit_i     (btb_hit),
    .btb_target_i  (btb_target),
    .pred_taken_i  (pred_taken),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (curr_pc)
  );

  assign fetch_pc_o = curr_pc;

endmodule

`default_nettype wire

// ==== testbench/tb_branch_unit.sv ====
// ------------------------------------------------------------
// Vector-driven testbench for the branch unit, reads steps from
// branch_unit_vectors.txt and checks the offered fetch address
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module tb_branch_unit;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 3;
  localparam int unsigned MAX_STALL    = 4;

  typedef enum logic [1:0] {OP_FETCH, OP_STALL, OP_RESOLVE, OP_FLUSH} op_e;

  // One line of the vector file, cycles is the number of clocks it lasts
  typedef struct packed {
    int               test;
    op_e              op;
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] target;
    logic             taken;
    logic             mispredict;
    logic [`XLEN-1:0] exp_pc;
    int               cycles;
  } step_t;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             flush_i;
  logic             res_valid_i;
  logic [`XLEN-1:0] res_pc_i;
  logic [`XLEN-1:0] res_target_i;
  logic             res_taken_i;
  logic             res_mispredict_i;
  logic             fetch_ready_i;
  logic             fetch_valid_o;
  logic [`XLEN-1:0] fetch_pc_o;

  step_t steps[$];
  int    budget_cycles = 0;
  int    tests;
  int    checks;
  int    errors;
  int    test_checks;
  int    test_errors;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  branch_unit u_branch_unit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_target_i     (res_target_i),
    .res_taken_i      (res_taken_i),
    .res_mispredict_i (res_mispredict_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_ready_i    (fetch_ready_i)
  );

  // ------------------------------------------------------------
  // Vector file parsing
  // ------------------------------------------------------------
  task automatic load_vectors();
    int               fd;
    int               fields;
    int               f_test;
    int               f_valid;
    int               f_taken;
    int               f_mis;
    logic [63:0]      f_op;
    logic [`XLEN-1:0] f_pc;
    logic [`XLEN-1:0] f_target;
    logic [`XLEN-1:0] f_exp;
    string            line;
    step_t            s;
    fd = $fopen("testbench/branch_unit_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open testbench/branch_unit_vectors.txt, no steps were run");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0) continue;
        // Comment lines start with a hash
        if (line.len() == 0 || line.getc(0) == "#") continue;
        fields = $sscanf(line, "%d %s %d %h %h %d %d %h", f_test, f_op, f_valid,
                         f_pc, f_target, f_taken, f_mis, f_exp);
        if (fields < 1) continue;
        if (fields != 8) begin
          errors++;
          $display("Vector line has the wrong number of columns: %s", line);
          continue;
        end
        s.test       = f_test;
        s.valid      = (f_valid != 0);
        s.pc         = f_pc;
        s.target     = f_target;
        s.taken      = (f_taken != 0);
        s.mispredict = (f_mis != 0);
        s.exp_pc     = f_exp;
        s.cycles     = 1;
        if (f_op == 64'("fetch")) begin
          s.op = OP_FETCH;
        end else if (f_op == 64'("stall")) begin
          // Back-pressure lasts a random number of cycles
          s.op     = OP_STALL;
          s.cycles = 1 + int'($urandom % MAX_STALL);
        end else if (f_op == 64'("resolve")) begin
          s.op = OP_RESOLVE;
        end else if (f_op == 64'("flush")) begin
          s.op = OP_FLUSH;
        end else begin
          errors++;
          $display("Unknown operation in vector line: %s", line);
          continue;
        end
        steps.push_back(s);
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------------------
  task automatic check_outputs(input step_t s);
    checks++;
    test_checks++;
    if (fetch_valid_o !== 1'b1) begin
      errors++;
      test_errors++;
      $display("FAIL test %0d: fetch_valid_o = 0x%h, expected 0x1", s.test, fetch_valid_o);
    end
    if (fetch_pc_o !== s.exp_pc) begin
      errors++;
      test_errors++;
      $display("FAIL test %0d: fetch_pc_o = 0x%h, expected 0x%h", s.test, fetch_pc_o,
               s.exp_pc);
    end
  endtask

  // Drive at the rising edge, look at the offered PC mid cycle
  task automatic apply_step(input step_t s);
    for (int c = 0; c < s.cycles; c++) begin
      @(posedge clk_i);
      res_valid_i      <= 1'b0;
      res_pc_i         <= '0;
      res_target_i     <= '0;
      res_taken_i      <= 1'b0;
      res_mispredict_i <= 1'b0;
      flush_i          <= 1'b0;
      fetch_ready_i    <= 1'b0;
      case (s.op)
        OP_FETCH: fetch_ready_i <= 1'b1;
        OP_FLUSH: flush_i <= 1'b1;
        OP_RESOLVE: begin
          res_valid_i      <= s.valid;
          res_pc_i         <= s.pc;
          res_target_i     <= s.target;
          res_taken_i      <= s.taken;
          res_mispredict_i <= s.mispredict;
        end
        default: begin
          // Stall, ready stays low
        end
      endcase
      @(negedge clk_i);
      check_outputs(s);
    end
  endtask

  task automatic close_test(input int test_num);
    tests++;
    $display("test %0d: %0d checks, %0d errors", test_num, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin : main
    int cur_test;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    fetch_ready_i    = 1'b0;
    tests            = 0;
    checks           = 0;
    errors           = 0;
    test_checks      = 0;
    test_errors      = 0;
    void'($urandom(32'h21bc_a232));
    load_vectors();
    // Reset plus every step plus some slack
    budget_cycles = RESET_CYCLES + 1 + 20;
    foreach (steps[i]) begin
      budget_cycles += steps[i].cycles;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    if (fetch_valid_o !== 1'b0) begin
      errors++;
      $display("FAIL reset: fetch_valid_o = 0x%h, expected 0x0", fetch_valid_o);
    end
    rst_ni <= 1'b1;
    cur_test = -1;
    foreach (steps[i]) begin
      if (steps[i].test != cur_test) begin
        if (cur_test >= 0) close_test(cur_test);
        cur_test = steps[i].test;
      end
      apply_step(steps[i]);
    end
    if (cur_test >= 0) close_test(cur_test);
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog, armed once the step count is known
  initial begin : watchdog
    wait (budget_cycles > 0);
    #(budget_cycles * CLK_PERIOD);
    $display("Timeout, the vector run did not finish within %0d cycles", budget_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/branch_unit_vectors.txt ====
# test op valid pc target taken mispredict expected_fetch_pc
# pc, target and expected are hex; expected is the PC offered during the step
1 fetch   0 0 0 0 0 00000100
1 fetch   0 0 0 0 0 00000104
1 fetch   0 0 0 0 0 00000108
1 fetch   0 0 0 0 0 0000010c
2 resolve 1 00000120 00000200 1 0 00000110
2 resolve 1 00000120 00000200 1 0 00000110
2 fetch   0 0 0 0 0 00000110
2 fetch   0 0 0 0 0 00000114
2 fetch   0 0 0 0 0 00000118
2 fetch   0 0 0 0 0 0000011c
2 fetch   0 0 0 0 0 00000120
2 fetch   0 0 0 0 0 00000200
2 fetch   0 0 0 0 0 00000204
3 resolve 1 00000300 00000400 1 1 00000208
3 resolve 0 0 0 0 0 00000208
3 fetch   0 0 0 0 0 00000400
3 fetch   0 0 0 0 0 00000404
3 resolve 1 00000500 00000000 0 1 00000408
3 resolve 0 0 0 0 0 00000408
3 fetch   0 0 0 0 0 00000504
3 fetch   0 0 0 0 0 00000508
4 stall   0 0 0 0 0 0000050c
4 fetch   0 0 0 0 0 0000050c
4 stall   0 0 0 0 0 00000510
4 fetch   0 0 0 0 0 00000510
4 stall   0 0 0 0 0 00000514
4 fetch   0 0 0 0 0 00000514
5 resolve 1 00000120 00000000 0 0 00000518
5 resolve 1 00000700 00000120 1 1 00000518
5 resolve 0 0 0 0 0 00000518
5 fetch   0 0 0 0 0 00000120
5 fetch   0 0 0 0 0 00000124
5 resolve 1 00000120 00000200 1 0 00000128
5 resolve 1 00000160 00000000 0 0 00000128
5 resolve 1 00000700 00000120 1 1 00000128
5 resolve 0 0 0 0 0 00000128
5 fetch   0 0 0 0 0 00000120
5 fetch   0 0 0 0 0 00000124
6 resolve 1 00000120 00000200 1 0 00000128
6 resolve 1 00000700 00000120 1 1 00000128
6 resolve 0 0 0 0 0 00000128
6 fetch   0 0 0 0 0 00000120
6 fetch   0 0 0 0 0 00000200
6 flush   0 0 0 0 0 00000204
6 resolve 1 00000700 00000120 1 1 00000204
6 resolve 0 0 0 0 0 00000204
6 fetch   0 0 0 0 0 00000120
6 fetch   0 0 0 0 0 00000124

// ==== all.f ====
+incdir+source
source/fetch_pkg.sv
source/resolution_if.sv
source/resolution_in.sv
source/btb.sv
source/bht.sv
source/pc_gen.sv
source/branch_unit.sv
testbench/tb_branch_unit.sv

// ==== Makefile ====
# Verilator build and run of the branch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_unit
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
